/* bench/bf_clock_gen.sv */
// Testbench clock and active-low reset
`default_nettype none

module bf_clock_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release just after an edge, same offset as the stimulus
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        reset_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* bench/bf_tb.sv */
// Testbench for the masked butterfly top level
// Random shared operands, reference arithmetic mod q, concurrent checks
`default_nettype none

`include "ntt_macros.svh"

module bf_tb;

    localparam int Q     = `NTT_Q;
    localparam int ITEMS = 24;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic accumulate;
    ntt_masked_pkg::bf_operands_t ops;
    ntt_masked_pkg::bf_mode_t     mode;
    ntt_masked_pkg::bf_result_t   result;

    logic [31:0] lfsr_state = 32'h074807d5;
    int hist_u [0:511];
    int hist_v [0:511];
    int hist_w [0:511];
    int slot = 0;
    int test_kind = 0;
    int item_first = 0;
    int item_count = 0;
    int zero_slot = 0;
    int armed = 0;
    int total_checks = 0;
    int u_errs = 0;
    int v_errs = 0;
    int other_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int share0_changes = 0;

    logic chk_u_en = 1'b0;
    logic chk_v_en = 1'b0;
    logic chk_vzero_en = 1'b0;
    logic chk_zero_en = 1'b0;
    logic chk_mask_en = 1'b0;
    logic mask_track = 1'b0;
    logic have_prev = 1'b0;
    logic [`NTT_WIDTH-1:0] prev_share0 = '0;
    logic [`NTT_WIDTH-1:0] exp_u = '0;
    logic [`NTT_WIDTH-1:0] exp_v = '0;
    logic [`NTT_WIDTH-1:0] res_u_plain;
    logic [`NTT_WIDTH-1:0] res_v_plain;

    bf_clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(8)) clk_gen_i (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    masked_bf_top dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize),
        .ops_i        (ops),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .result_o     (result)
    );

    function automatic logic [`NTT_WIDTH-1:0] unmask(input ntt_masked_pkg::masked_coeff_t c);
        int s;
        s = (int'(c.share0) + int'(c.share1)) % Q;
        return s[`NTT_WIDTH-1:0];
    endfunction

    assign res_u_plain = unmask(result.u);
    assign res_v_plain = unmask(result.v);

    // Expectations change only after the drive delay, so edges see stable values
    a_u: assert property (@(posedge clk) chk_u_en |-> (res_u_plain == exp_u))
        else begin
            $display("mismatch result_o.u unmasked: got %h expected %h",
                     $sampled(res_u_plain), $sampled(exp_u));
            u_errs++;
        end

    a_v: assert property (@(posedge clk) chk_v_en |-> (res_v_plain == exp_v))
        else begin
            $display("mismatch result_o.v unmasked: got %h expected %h",
                     $sampled(res_v_plain), $sampled(exp_v));
            v_errs++;
        end

    a_vzero: assert property (@(posedge clk) chk_vzero_en |-> (result.v == '0))
        else begin
            $display("mismatch result_o.v: got %h expected %h", $sampled(result.v), 24'h0);
            other_errs++;
        end

    a_zero: assert property (@(posedge clk) chk_zero_en |-> (result == '0))
        else begin
            $display("mismatch result_o: got %h expected %h", $sampled(result), 48'h0);
            other_errs++;
        end

    a_mask: assert property (@(posedge clk) chk_mask_en |-> (share0_changes != 0))
        else begin
            $display("share0 of result_o.u stayed constant over identical operands");
            other_errs++;
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
    endtask

    task automatic rand_below_q(output int r);
        logic [31:0] bits;
        draw_bits(`NTT_WIDTH, bits);
        r = int'(bits);
        if (r >= Q) begin
            r = r - Q;
        end
    endtask

    task automatic make_share(input int plain, output ntt_masked_pkg::masked_coeff_t c);
        int m;
        rand_below_q(m);
        c.share0 = m[`NTT_WIDTH-1:0];
        c.share1 = `NTT_WIDTH'((plain - m + Q) % Q);
    endtask

    task automatic rand_operands(output ntt_masked_pkg::bf_operands_t o,
                                 output int u, output int v, output int w);
        rand_below_q(u);
        rand_below_q(v);
        rand_below_q(w);
        make_share(u, o.u);
        make_share(v, o.v);
        make_share(w, o.w);
    endtask

    // Output seen at the next edge belongs to the item latency slots back
    task automatic arm_checks();
        int k;
        chk_u_en = 1'b0;
        chk_v_en = 1'b0;
        chk_vzero_en = 1'b0;
        chk_zero_en = 1'b0;
        chk_mask_en = 1'b0;
        case (test_kind)
            1: begin
                k = slot - 6;
                if (k >= item_first && k < item_first + item_count) begin
                    chk_u_en = 1'b1;
                    chk_v_en = 1'b1;
                    exp_u = `NTT_WIDTH'((hist_u[k] + hist_v[k]) % Q);
                    exp_v = `NTT_WIDTH'((((hist_u[k] - hist_v[k] + Q) % Q) * hist_w[k]) % Q);
                    armed++;
                    if (mask_track) begin
                        if (have_prev && result.u.share0 != prev_share0) begin
                            share0_changes++;
                        end
                        prev_share0 = result.u.share0;
                        have_prev = 1'b1;
                    end
                end
            end
            2: begin
                k = slot - 3;
                if (k >= item_first && k < item_first + item_count) begin
                    chk_u_en = 1'b1;
                    chk_vzero_en = 1'b1;
                    exp_u = `NTT_WIDTH'((hist_u[k] * hist_v[k]) % Q);
                    armed++;
                end
            end
            3: begin
                k = slot - 6;
                if (k >= item_first && k < item_first + item_count) begin
                    chk_u_en = 1'b1;
                    exp_u = `NTT_WIDTH'((hist_u[k] * hist_v[k] + hist_w[k+4]) % Q);
                    armed++;
                end
            end
            4: begin
                k = slot - zero_slot;
                if (k >= 1 && k <= 6) begin
                    chk_u_en = 1'b1;
                    chk_v_en = 1'b1;
                    exp_u = '0;
                    exp_v = '0;
                    // Fresh masks reach the output registers after two cycles
                    chk_zero_en = (k <= 2);
                    armed++;
                end
            end
            5: chk_mask_en = 1'b1;
            default: ;
        endcase
        if (chk_u_en || chk_mask_en) begin
            total_checks++;
        end
    endtask

    task automatic drive_slot(input ntt_masked_pkg::bf_operands_t o, input int u,
                              input int v, input int w, input ntt_masked_pkg::bf_mode_t m,
                              input logic acc, input logic zero);
        @(posedge clk);
        #2;
        ops = o;
        mode = m;
        accumulate = acc;
        zeroize = zero;
        hist_u[slot] = u;
        hist_v[slot] = v;
        hist_w[slot] = w;
        arm_checks();
        slot++;
    endtask

    task automatic drain(input ntt_masked_pkg::bf_mode_t m, input logic acc, input int target);
        int iter;
        iter = 0;
        while (armed < target) begin
            iter++;
            if (iter > 20) begin
                $display("timeout: only %0d of %0d results reached the output", armed, target);
                $display("Simulation failed");
                $finish;
            end else begin
                drive_slot('0, 0, 0, 0, m, acc, 1'b0);
            end
        end
        // One more edge for the last armed check
        test_kind = 0;
        drive_slot('0, 0, 0, 0, m, acc, 1'b0);
    endtask

    task automatic report(input string name, input int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s (%0d errors)", tests_run, name,
                 (errs == 0) ? "PASS" : "FAIL", errs);
    endtask

    task automatic start_test(input int kind, input int count);
        test_kind = kind;
        armed = 0;
        item_first = slot;
        item_count = count;
    endtask

    initial begin
        ntt_masked_pkg::bf_operands_t o;
        ntt_masked_pkg::masked_coeff_t w_store [0:ITEMS+3];
        int w_plain [0:ITEMS+3];
        int u, v, w, iter, u0, v0, e0;

        ops = '0;
        mode = ntt_masked_pkg::gs_mode;
        accumulate = 1'b0;
        zeroize = 1'b0;

        iter = 0;
        while (reset_n !== 1'b1) begin
            iter++;
            if (iter > 20) begin
                $display("timeout: reset never released");
                $display("Simulation failed");
                $finish;
            end else begin
                @(posedge clk);
            end
        end

        // GS stream, one set per cycle
        u0 = u_errs;
        v0 = v_errs;
        start_test(1, ITEMS);
        for (int i = 0; i < ITEMS; i++) begin
            rand_operands(o, u, v, w);
            drive_slot(o, u, v, w, ntt_masked_pkg::gs_mode, 1'b0, 1'b0);
        end
        drain(ntt_masked_pkg::gs_mode, 1'b0, ITEMS);
        report("gs u = u + v", u_errs - u0);
        report("gs v = (u - v) * w", v_errs - v0);

        e0 = u_errs + v_errs + other_errs;
        start_test(2, ITEMS);
        for (int i = 0; i < ITEMS; i++) begin
            rand_operands(o, u, v, w);
            drive_slot(o, u, v, w, ntt_masked_pkg::pwm_mode, 1'b0, 1'b0);
        end
        drain(ntt_masked_pkg::pwm_mode, 1'b0, ITEMS);
        report("pwm u * v", u_errs + v_errs + other_errs - e0);

        // w trails its u and v by four slots
        e0 = u_errs + v_errs + other_errs;
        start_test(3, ITEMS);
        for (int i = 0; i < ITEMS + 4; i++) begin
            rand_operands(o, u, v, w);
            w_store[i] = o.w;
            w_plain[i] = w;
            if (i >= ITEMS) begin
                o.u = '0;
                o.v = '0;
                u = 0;
                v = 0;
            end
            if (i >= 4) begin
                o.w = w_store[i-4];
                w = w_plain[i-4];
            end else begin
                o.w = '0;
                w = 0;
            end
            drive_slot(o, u, v, w, ntt_masked_pkg::pwm_mode, 1'b1, 1'b0);
        end
        drain(ntt_masked_pkg::pwm_mode, 1'b1, ITEMS);
        report("pwm u * v + w", u_errs + v_errs + other_errs - e0);

        e0 = u_errs + v_errs + other_errs;
        share0_changes = 0;
        have_prev = 1'b0;
        mask_track = 1'b1;
        start_test(1, 16);
        rand_operands(o, u, v, w);
        for (int i = 0; i < 16; i++) begin
            drive_slot(o, u, v, w, ntt_masked_pkg::gs_mode, 1'b0, 1'b0);
        end
        drain(ntt_masked_pkg::gs_mode, 1'b0, 16);
        mask_track = 1'b0;
        test_kind = 5;
        drive_slot('0, 0, 0, 0, ntt_masked_pkg::gs_mode, 1'b0, 1'b0);
        test_kind = 0;
        drive_slot('0, 0, 0, 0, ntt_masked_pkg::gs_mode, 1'b0, 1'b0);
        report("mask refresh", u_errs + v_errs + other_errs - e0);

        // Live data in flight when zeroize arrives
        e0 = u_errs + v_errs + other_errs;
        for (int i = 0; i < 6; i++) begin
            rand_operands(o, u, v, w);
            drive_slot(o, u, v, w, ntt_masked_pkg::gs_mode, 1'b0, 1'b0);
        end
        start_test(4, 6);
        zero_slot = slot;
        drive_slot('0, 0, 0, 0, ntt_masked_pkg::gs_mode, 1'b0, 1'b1);
        drain(ntt_masked_pkg::gs_mode, 1'b0, 6);
        report("zeroize", u_errs + v_errs + other_errs - e0);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, total_checks, u_errs + v_errs + other_errs);
        if (tests_failed == 0 && u_errs + v_errs + other_errs == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/mask_rng.sv */
// Five 16-bit Fibonacci LFSRs, each folded to a word below q
`default_nettype none

`include "ntt_macros.svh"

module mask_rng (
    input  wire                       clk,
    input  wire                       reset_n,
    output ntt_masked_pkg::mask_rnd_t rnd_o
);

    localparam logic [4:0][15:0] SEEDS = {
        16'h9e37, 16'h4a1d, 16'hc3b5, 16'h2f68, 16'h71d2
    };

    logic [4:0][15:0]            lfsr_q;
    logic [4:0]                  feedback;
    logic [4:0][`NTT_WIDTH-1:0]  folded;
    logic [4:0][`NTT_WIDTH-1:0]  word;

    // x^16 + x^14 + x^13 + x^11 + 1
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            feedback[i] = lfsr_q[i][15] ^ lfsr_q[i][13] ^ lfsr_q[i][12] ^ lfsr_q[i][10];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lfsr_q <= SEEDS;
        end else begin
            for (int i = 0; i < 5; i++) begin
                lfsr_q[i] <= {lfsr_q[i][14:0], feedback[i]};
            end
        end
    end

    // Top nibble folded in, then one conditional subtract
    always_comb begin
        for (int i = 0; i < 5; i++) begin
            folded[i] = lfsr_q[i][`NTT_WIDTH-1:0] ^ {8'h00, lfsr_q[i][15:12]};
            if (folded[i] >= `NTT_Q) begin
                word[i] = folded[i] - `NTT_Q;
            end else begin
                word[i] = folded[i];
            end
        end
    end

    assign rnd_o.rnd0 = word[0];
    assign rnd_o.rnd1 = word[1];
    assign rnd_o.rnd2 = word[2];
    assign rnd_o.rnd3 = word[3];
    assign rnd_o.rnd4 = word[4];

endmodule

`default_nettype wire

/* design/masked_add_sub.sv */
// Two-stage masked modular adder/subtractor
// Stage 1 combines shares, stage 2 refreshes the mask
`default_nettype none

`include "ntt_macros.svh"

module masked_add_sub (
    input  wire                           clk,
    input  wire                           reset_n,
    input  wire                           zeroize_i,
    input  wire                           sub_i,
    input  wire ntt_masked_pkg::masked_coeff_t a_i,
    input  wire ntt_masked_pkg::masked_coeff_t b_i,
    input  wire [`NTT_WIDTH-1:0]          rnd_a_i,
    input  wire [`NTT_WIDTH-1:0]          rnd_b_i,
    output ntt_masked_pkg::masked_coeff_t res_o
);

    logic [`NTT_WIDTH-1:0] comb0, comb1;
    ntt_masked_pkg::masked_coeff_t stage1_d, stage1_q;
    ntt_masked_pkg::masked_coeff_t stage2_d, stage2_q;

    // Share by share, so the true value never appears
    always_comb begin
        if (sub_i) begin
            comb0 = ntt_masked_pkg::mod_sub(a_i.share0, b_i.share0);
            comb1 = ntt_masked_pkg::mod_sub(a_i.share1, b_i.share1);
        end else begin
            comb0 = ntt_masked_pkg::mod_add(a_i.share0, b_i.share0);
            comb1 = ntt_masked_pkg::mod_add(a_i.share1, b_i.share1);
        end
    end

    // rnd_b moves between shares before the first register
    assign stage1_d.share0 = ntt_masked_pkg::mod_add(comb0, rnd_b_i);
    assign stage1_d.share1 = ntt_masked_pkg::mod_sub(comb1, rnd_b_i);

    // Refresh with rnd_a
    assign stage2_d.share0 = ntt_masked_pkg::mod_add(stage1_q.share0, rnd_a_i);
    assign stage2_d.share1 = ntt_masked_pkg::mod_sub(stage1_q.share1, rnd_a_i);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage1_q <= '0;
            stage2_q <= '0;
        end else if (zeroize_i) begin
            stage1_q <= '0;
            stage2_q <= '0;
        end else begin
            stage1_q <= stage1_d;
            stage2_q <= stage2_d;
        end
    end

    assign res_o = stage2_q;

endmodule

`default_nettype wire

/* design/masked_bf_top.sv */
// Top level, masked butterfly fed by the mask generator
`default_nettype none

module masked_bf_top (
    input  wire                               clk,
    input  wire                               reset_n,
    input  wire                               zeroize_i,
    input  wire ntt_masked_pkg::bf_operands_t ops_i,
    input  wire ntt_masked_pkg::bf_mode_t     mode_i,
    input  wire                               accumulate_i,
    output ntt_masked_pkg::bf_result_t        result_o
);

    // Fresh every cycle, no handshake
    ntt_masked_pkg::mask_rnd_t rnd;

    mask_rng rng_i (
        .clk     (clk),
        .reset_n (reset_n),
        .rnd_o   (rnd)
    );

    masked_gs_butterfly bf_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .ops_i        (ops_i),
        .rnd_i        (rnd),
        .mode_i       (mode_i),
        .accumulate_i (accumulate_i),
        .result_o     (result_o)
    );

endmodule

`default_nettype wire

/* design/masked_gs_butterfly.sv */
// Masked Gentleman-Sande butterfly with point-wise multiply mode
// GS: u+v and (u-v)*w in 6 cycles; pwm: u*v in 3, u*v+w in 6
`default_nettype none

`include "ntt_macros.svh"

module masked_gs_butterfly (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire ntt_masked_pkg::bf_operands_t  ops_i,
    input  wire ntt_masked_pkg::mask_rnd_t     rnd_i,
    input  wire ntt_masked_pkg::bf_mode_t      mode_i,
    input  wire                                accumulate_i,
    output ntt_masked_pkg::bf_result_t         result_o
);

    logic is_pwm;
    logic acc_sel;

    ntt_masked_pkg::masked_coeff_t add_a, add_b, add_res, add_res_dly;
    ntt_masked_pkg::masked_coeff_t sub_res, w_dly;
    ntt_masked_pkg::masked_coeff_t mul_a, mul_b, mul_res, mul_res_q;
    ntt_masked_pkg::masked_coeff_t u_out_q, v_out_q;

    assign is_pwm  = (mode_i == ntt_masked_pkg::pwm_mode);
    assign acc_sel = is_pwm & accumulate_i;

    // Accumulate reuses the adder: registered product plus the late w
    assign add_a = acc_sel ? mul_res_q : ops_i.u;
    assign add_b = acc_sel ? ops_i.w : ops_i.v;

    masked_add_sub add_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b0),
        .a_i       (add_a),
        .b_i       (add_b),
        .rnd_a_i   (rnd_i.rnd0),
        .rnd_b_i   (rnd_i.rnd1),
        .res_o     (add_res)
    );

    // Other word order than the adder
    masked_add_sub sub_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .a_i       (ops_i.u),
        .b_i       (ops_i.v),
        .rnd_a_i   (rnd_i.rnd1),
        .rnd_b_i   (rnd_i.rnd2),
        .res_o     (sub_res)
    );

    // w waits for u-v
    share_delay #(
        .payload_t (ntt_masked_pkg::masked_coeff_t),
        .DEPTH     (`ADD_SUB_LATENCY)
    ) w_dly_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (ops_i.w),
        .q_o       (w_dly)
    );

    assign mul_a = is_pwm ? ops_i.u : sub_res;
    assign mul_b = is_pwm ? ops_i.v : w_dly;

    masked_mult mult_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .rnd_i     ({rnd_i.rnd4, rnd_i.rnd3, rnd_i.rnd2}),
        .res_o     (mul_res)
    );

    // u+v waits for the multiplier
    share_delay #(
        .payload_t (ntt_masked_pkg::masked_coeff_t),
        .DEPTH     (`MULT_LATENCY)
    ) add_dly_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .d_i       (add_res),
        .q_o       (add_res_dly)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mul_res_q <= '0;
            u_out_q   <= '0;
            v_out_q   <= '0;
        end else if (zeroize_i) begin
            mul_res_q <= '0;
            u_out_q   <= '0;
            v_out_q   <= '0;
        end else begin
            mul_res_q <= mul_res;
            u_out_q   <= add_res_dly;
            v_out_q   <= mul_res;
        end
    end

    // pwm results bypass the output register
    always_comb begin
        if (is_pwm) begin
            result_o.u = accumulate_i ? add_res : mul_res;
            result_o.v = '0;
        end else begin
            result_o.u = u_out_q;
            result_o.v = v_out_q;
        end
    end

endmodule

`default_nettype wire

/* design/masked_mult.sv */
// Three-stage masked modular multiplier
// Cross products, Barrett reduction, refreshed recombination
`default_nettype none

`include "ntt_macros.svh"

module masked_mult (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire ntt_masked_pkg::masked_coeff_t a_i,
    input  wire ntt_masked_pkg::masked_coeff_t b_i,
    input  wire [2:0][`NTT_WIDTH-1:0]          rnd_i,
    output ntt_masked_pkg::masked_coeff_t      res_o
);

    localparam int W = `NTT_WIDTH;
    // floor(2^24 / 3329)
    localparam logic [12:0] BARRETT_M = 13'd5039;

    logic [2*W-1:0] p00_q, p01_q, p10_q, p11_q;
    logic [W-1:0]   t00_q, t01_q, t10_q, t11_q;
    ntt_masked_pkg::masked_coeff_t res_q;

    // Estimate is low by at most one q, so one correction step
    function automatic logic [W-1:0] reduce_prod(input logic [2*W-1:0] x);
        logic [2*W+12:0] scaled;
        logic [12:0]     qhat;
        logic [2*W-1:0]  qmul;
        logic [2*W-1:0]  diff;
        logic [W:0]      rem;
        scaled = x * BARRETT_M;
        qhat = scaled[2*W+12:2*W];
        qmul = qhat * `NTT_Q;
        diff = x - qmul;
        rem = diff[W:0];
        if (rem >= {1'b0, `NTT_Q}) begin
            rem = rem - {1'b0, `NTT_Q};
        end
        return rem[W-1:0];
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            p00_q <= '0;
            p01_q <= '0;
            p10_q <= '0;
            p11_q <= '0;
            t00_q <= '0;
            t01_q <= '0;
            t10_q <= '0;
            t11_q <= '0;
            res_q <= '0;
        end else if (zeroize_i) begin
            p00_q <= '0;
            p01_q <= '0;
            p10_q <= '0;
            p11_q <= '0;
            t00_q <= '0;
            t01_q <= '0;
            t10_q <= '0;
            t11_q <= '0;
            res_q <= '0;
        end else begin
            // Stage 1
            p00_q <= a_i.share0 * b_i.share0;
            p01_q <= a_i.share0 * b_i.share1;
            p10_q <= a_i.share1 * b_i.share0;
            p11_q <= a_i.share1 * b_i.share1;
            // Stage 2, cross terms masked with rnd 0, diagonal with rnd 1
            t00_q <= ntt_masked_pkg::mod_add(reduce_prod(p00_q), rnd_i[1]);
            t11_q <= ntt_masked_pkg::mod_sub(reduce_prod(p11_q), rnd_i[1]);
            t01_q <= ntt_masked_pkg::mod_add(reduce_prod(p01_q), rnd_i[0]);
            t10_q <= ntt_masked_pkg::mod_sub(reduce_prod(p10_q), rnd_i[0]);
            // Stage 3
            res_q.share0 <= ntt_masked_pkg::mod_add(
                ntt_masked_pkg::mod_add(t00_q, t01_q), rnd_i[2]);
            res_q.share1 <= ntt_masked_pkg::mod_sub(
                ntt_masked_pkg::mod_add(t11_q, t10_q), rnd_i[2]);
        end
    end

    assign res_o = res_q;

endmodule

`default_nettype wire

/* design/ntt_macros.svh */
// Modulus, share width and pipeline latencies
// for the masked inverse NTT butterfly

`ifndef NTT_MACROS_SVH
`define NTT_MACROS_SVH

// ML-KEM prime
`define NTT_Q 12'd3329

// Bits per arithmetic share, every share held below NTT_Q
`define NTT_WIDTH 12

// Cycles through masked_add_sub
`define ADD_SUB_LATENCY 2

// Cycles through masked_mult
`define MULT_LATENCY 3

`endif

/* design/ntt_masked_pkg.sv */
// Types shared by the masked butterfly blocks
// plus the share-wise modular add and subtract helpers
`default_nettype none

`include "ntt_macros.svh"

package ntt_masked_pkg;

    // Two arithmetic shares, true value is (share0 + share1) mod q
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] share0;
        logic [`NTT_WIDTH-1:0] share1;
    } masked_coeff_t;

    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
        masked_coeff_t w;
    } bf_operands_t;

    typedef struct packed {
        masked_coeff_t u;
        masked_coeff_t v;
    } bf_result_t;

    // Fresh words, each already below q
    typedef struct packed {
        logic [`NTT_WIDTH-1:0] rnd0;
        logic [`NTT_WIDTH-1:0] rnd1;
        logic [`NTT_WIDTH-1:0] rnd2;
        logic [`NTT_WIDTH-1:0] rnd3;
        logic [`NTT_WIDTH-1:0] rnd4;
    } mask_rnd_t;

    typedef enum logic {
        gs_mode  = 1'b0,
        pwm_mode = 1'b1
    } bf_mode_t;

    // Both operands below q
    function automatic logic [`NTT_WIDTH-1:0] mod_add(input logic [`NTT_WIDTH-1:0] a,
                                                      input logic [`NTT_WIDTH-1:0] b);
        logic [`NTT_WIDTH:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, `NTT_Q}) begin
            sum = sum - {1'b0, `NTT_Q};
        end
        return sum[`NTT_WIDTH-1:0];
    endfunction

    // a + q - b never goes negative and stays below 2q
    function automatic logic [`NTT_WIDTH-1:0] mod_sub(input logic [`NTT_WIDTH-1:0] a,
                                                      input logic [`NTT_WIDTH-1:0] b);
        logic [`NTT_WIDTH:0] diff;
        diff = {1'b0, a} + {1'b0, `NTT_Q} - {1'b0, b};
        if (diff >= {1'b0, `NTT_Q}) begin
            diff = diff - {1'b0, `NTT_Q};
        end
        return diff[`NTT_WIDTH-1:0];
    endfunction

endpackage

`default_nettype wire

/* design/share_delay.sv */
// Zeroizable shift register for any packed payload
`default_nettype none

module share_delay #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  wire           clk,
    input  wire           reset_n,
    input  wire           zeroize_i,
    input  wire payload_t d_i,
    output payload_t      q_o
);

    payload_t dly_q [DEPTH];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                dly_q[i] <= '0;
            end
        end else if (zeroize_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    // Oldest entry
    assign q_o = dly_q[DEPTH-1];

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/ntt_masked_pkg.sv
design/masked_add_sub.sv
design/masked_mult.sv
design/share_delay.sv
design/masked_gs_butterfly.sv
design/mask_rng.sv
design/masked_bf_top.sv
bench/bf_clock_gen.sv
bench/bf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module bf_tb -f project.f
output="$(./obj_dir/Vbf_tb)"
echo "$output"

if grep -q "Simulation completed successfully" <<< "$output"; then
    exit 0
else
    exit 1
fi
